// ==== hw/csb_pkg.sv ====
// ==========================================================
// CSB bus definitions shared by the MCIF config slave:
// request and response packets, opcodes and field widths
// ==========================================================
package csb_pkg;

  // field widths
  localparam int CSB_DATA_W  = 32;
  localparam int CSB_ADDR_W  = 22;  // word address
  localparam int CSB_BE_W    = 4;
  localparam int CSB_LEVEL_W = 2;

  // response kind, top bit of the response packet
  typedef enum logic {
    rsp_read  = 1'b0,
    rsp_write = 1'b1
  } csb_rsp_kind_e;

  // decoded request opcode
  typedef enum logic [1:0] {
    op_read          = 2'd0,
    op_write_posted  = 2'd1,
    op_write_nposted = 2'd2
  } csb_op_e;

  // 63-bit request packet, msb first
  typedef struct packed {
    logic [CSB_LEVEL_W-1:0] level;    // carried, not decoded
    logic [CSB_BE_W-1:0]    wrbe;
    logic                   srcpriv;  // carried, not decoded
    logic                   nposted;
    logic                   write;
    logic [CSB_DATA_W-1:0]  wdat;
    logic [CSB_ADDR_W-1:0]  addr;
  } csb_req_t;

  // 34-bit response packet
  typedef struct packed {
    csb_rsp_kind_e         kind;
    logic                  error;
    logic [CSB_DATA_W-1:0] rdat;
  } csb_rsp_t;

endpackage

// ==== hw/mcif_reg_pkg.sv ====
// ==========================================================
// MCIF register map: word offsets, reset values and the
// configuration struct handed to the datapath
// ==========================================================
package mcif_reg_pkg;

  localparam int REG_OFFSET_W = 10;  // low bits of the word address
  localparam int NUM_RW_REGS  = 6;   // offsets 0..5 are writable

  localparam logic [7:0] OS_CNT_RESET   = 8'hff;
  localparam logic [7:0] WEIGHT_RESET   = 8'h01;
  localparam logic [3:0] OS_CNT_WR_MASK = 4'b0011;  // only two limit bytes exist

  // register word offsets
  typedef enum logic [3:0] {
    reg_os_cnt      = 4'd0,
    reg_rd_weight_0 = 4'd1,
    reg_rd_weight_1 = 4'd2,
    reg_rd_weight_2 = 4'd3,
    reg_wr_weight_0 = 4'd4,
    reg_wr_weight_1 = 4'd5,
    reg_status      = 4'd6   // read-only
  } mcif_reg_e;

  // all settings for the datapath, 176 bits
  typedef struct packed {
    logic [7:0] rd_os_cnt;
    logic [7:0] wr_os_cnt;
    logic [7:0] rd_weight_bdma;
    logic [7:0] rd_weight_sdp;
    logic [7:0] rd_weight_sdp_b;
    logic [7:0] rd_weight_sdp_n;
    logic [7:0] rd_weight_sdp_e;
    logic [7:0] rd_weight_cdp;
    logic [7:0] rd_weight_pdp;
    logic [7:0] rd_weight_rbk;
    logic [7:0] rd_weight_cdma_dat;
    logic [7:0] rd_weight_cdma_wt;
    logic [7:0] rd_weight_rsv_0;
    logic [7:0] rd_weight_rsv_1;
    logic [7:0] wr_weight_bdma;
    logic [7:0] wr_weight_sdp;
    logic [7:0] wr_weight_pdp;
    logic [7:0] wr_weight_cdp;
    logic [7:0] wr_weight_rbk;
    logic [7:0] wr_weight_rsv_0;
    logic [7:0] wr_weight_rsv_1;
    logic [7:0] wr_weight_rsv_2;
  } mcif_cfg_t;

endpackage

// ==== hw/mcif_csb_reg.sv ====
// ==========================================================
// MCIF register file: byte-enabled writes, read mux, error
// decode and the packed configuration output
// ==========================================================
`timescale 1ns/1ps
module mcif_csb_reg (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic [mcif_reg_pkg::REG_OFFSET_W-1:0] reg_offset,
  input  logic                                  reg_wr_en,
  input  logic [csb_pkg::CSB_DATA_W-1:0]        reg_wr_data,
  input  logic [csb_pkg::CSB_BE_W-1:0]          reg_wr_be,
  input  logic                                  idle,
  output logic [csb_pkg::CSB_DATA_W-1:0]        reg_rd_data,
  output logic                                  reg_err,
  output mcif_reg_pkg::mcif_cfg_t               reg2dp_cfg
);

  logic [mcif_reg_pkg::NUM_RW_REGS-1:0][csb_pkg::CSB_DATA_W-1:0] reg_q;
  mcif_reg_pkg::mcif_reg_e              reg_sel;
  logic                                 sel_mapped;
  logic                                 sel_rw;
  logic                                 wr_hit;
  logic [csb_pkg::CSB_BE_W-1:0]         byte_we;

  assign reg_sel = mcif_reg_pkg::mcif_reg_e'(reg_offset[3:0]);

  // ========================================================
  // address decode and read mux
  // ========================================================
  always_comb begin
    sel_mapped  = 1'b0;
    sel_rw      = 1'b0;
    reg_rd_data = '0;  // unmapped reads as zero
    if (reg_offset[mcif_reg_pkg::REG_OFFSET_W-1:4] == '0) begin
      case (reg_sel)
        mcif_reg_pkg::reg_os_cnt,
        mcif_reg_pkg::reg_rd_weight_0,
        mcif_reg_pkg::reg_rd_weight_1,
        mcif_reg_pkg::reg_rd_weight_2,
        mcif_reg_pkg::reg_wr_weight_0,
        mcif_reg_pkg::reg_wr_weight_1: begin
          sel_mapped  = 1'b1;
          sel_rw      = 1'b1;
          reg_rd_data = reg_q[reg_offset[2:0]];
        end
        mcif_reg_pkg::reg_status: begin
          sel_mapped  = 1'b1;
          reg_rd_data = {{(csb_pkg::CSB_DATA_W-1){1'b0}}, idle};
        end
        default: begin
        end
      endcase
    end
  end

  // unmapped offset, or a write to the status word
  assign reg_err = ~sel_mapped | (reg_wr_en & ~sel_rw);

  // ========================================================
  // register storage
  // ========================================================
  assign wr_hit  = reg_wr_en & sel_rw;
  assign byte_we = reg_wr_be & ((reg_sel == mcif_reg_pkg::reg_os_cnt) ?
                                mcif_reg_pkg::OS_CNT_WR_MASK : 4'hf);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      reg_q[0] <= {16'h0, mcif_reg_pkg::OS_CNT_RESET, mcif_reg_pkg::OS_CNT_RESET};
      for (int r = 1; r < mcif_reg_pkg::NUM_RW_REGS; r++) begin
        reg_q[r] <= {4{mcif_reg_pkg::WEIGHT_RESET}};
      end
    end else if (wr_hit) begin
      for (int b = 0; b < csb_pkg::CSB_BE_W; b++) begin
        if (byte_we[b]) begin
          reg_q[reg_offset[2:0]][8*b +: 8] <= reg_wr_data[8*b +: 8];
        end
      end
    end
  end

  // ========================================================
  // configuration fields, low byte up
  // ========================================================
  assign reg2dp_cfg.rd_os_cnt          = reg_q[0][7:0];
  assign reg2dp_cfg.wr_os_cnt          = reg_q[0][15:8];
  assign reg2dp_cfg.rd_weight_bdma     = reg_q[1][7:0];
  assign reg2dp_cfg.rd_weight_sdp      = reg_q[1][15:8];
  assign reg2dp_cfg.rd_weight_sdp_b    = reg_q[1][23:16];
  assign reg2dp_cfg.rd_weight_sdp_n    = reg_q[1][31:24];
  assign reg2dp_cfg.rd_weight_sdp_e    = reg_q[2][7:0];
  assign reg2dp_cfg.rd_weight_cdp      = reg_q[2][15:8];
  assign reg2dp_cfg.rd_weight_pdp      = reg_q[2][23:16];
  assign reg2dp_cfg.rd_weight_rbk      = reg_q[2][31:24];
  assign reg2dp_cfg.rd_weight_cdma_dat = reg_q[3][7:0];
  assign reg2dp_cfg.rd_weight_cdma_wt  = reg_q[3][15:8];
  assign reg2dp_cfg.rd_weight_rsv_0    = reg_q[3][23:16];
  assign reg2dp_cfg.rd_weight_rsv_1    = reg_q[3][31:24];
  assign reg2dp_cfg.wr_weight_bdma     = reg_q[4][7:0];
  assign reg2dp_cfg.wr_weight_sdp      = reg_q[4][15:8];
  assign reg2dp_cfg.wr_weight_pdp      = reg_q[4][23:16];
  assign reg2dp_cfg.wr_weight_cdp      = reg_q[4][31:24];
  assign reg2dp_cfg.wr_weight_rbk      = reg_q[5][7:0];
  assign reg2dp_cfg.wr_weight_rsv_0    = reg_q[5][15:8];
  assign reg2dp_cfg.wr_weight_rsv_1    = reg_q[5][23:16];
  assign reg2dp_cfg.wr_weight_rsv_2    = reg_q[5][31:24];

  // register contents only move on a write cycle
  a_no_spurious_write: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !reg_wr_en |=> $stable(reg_q)
  ) else $error("register changed without a write");

endmodule

// ==== hw/mcif_csb.sv ====
// ==========================================================
// CSB protocol block of the MCIF config slave: captures and
// decodes requests, drives the register file, returns responses
// ==========================================================
`timescale 1ns/1ps
module mcif_csb (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  logic                    csb2mcif_req_pvld,
  input  csb_pkg::csb_req_t       csb2mcif_req_pd,
  input  logic                    dp2reg_idle,
  output logic                    mcif2csb_resp_valid,
  output csb_pkg::csb_rsp_t       mcif2csb_resp_pd,
  output mcif_reg_pkg::mcif_cfg_t reg2dp_cfg
);

  logic                                  req_vld;
  csb_pkg::csb_req_t                     req_pd;
  csb_pkg::csb_op_e                      req_op;
  logic [mcif_reg_pkg::REG_OFFSET_W-1:0] reg_offset;
  logic                                  reg_wr_en;
  logic [csb_pkg::CSB_DATA_W-1:0]        reg_wr_data;
  logic [csb_pkg::CSB_BE_W-1:0]          reg_wr_be;
  logic [csb_pkg::CSB_DATA_W-1:0]        reg_rd_data;
  logic                                  reg_err;
  logic                                  rsp_vld;
  csb_pkg::csb_rsp_t                     rsp_pd;

  // ========================================================
  // request capture
  // ========================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld <= 1'b0;
    end else begin
      req_vld <= csb2mcif_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2mcif_req_pvld) begin
      req_pd <= csb2mcif_req_pd;  // payload held until next strobe
    end
  end

  always_comb begin
    if (!req_pd.write) begin
      req_op = csb_pkg::op_read;
    end else if (req_pd.nposted) begin
      req_op = csb_pkg::op_write_nposted;
    end else begin
      req_op = csb_pkg::op_write_posted;
    end
  end

  assign reg_offset  = req_pd.addr[mcif_reg_pkg::REG_OFFSET_W-1:0];
  assign reg_wr_en   = req_vld & (req_op != csb_pkg::op_read);  // commits next edge
  assign reg_wr_data = req_pd.wdat;
  assign reg_wr_be   = req_pd.wrbe;

  mcif_csb_reg u_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_offset      (reg_offset),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_data     (reg_wr_data),
    .reg_wr_be       (reg_wr_be),
    .idle            (dp2reg_idle),
    .reg_rd_data     (reg_rd_data),
    .reg_err         (reg_err),
    .reg2dp_cfg      (reg2dp_cfg)
  );

  // ========================================================
  // response
  // ========================================================
  assign rsp_vld = req_vld & (req_op != csb_pkg::op_write_posted);  // posted writes are silent

  always_comb begin
    rsp_pd.kind  = (req_op == csb_pkg::op_read) ? csb_pkg::rsp_read : csb_pkg::rsp_write;
    rsp_pd.error = reg_err;
    rsp_pd.rdat  = (req_op == csb_pkg::op_read) ? reg_rd_data : '0;
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      mcif2csb_resp_valid <= 1'b0;
    end else begin
      mcif2csb_resp_valid <= rsp_vld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rsp_vld) begin
      mcif2csb_resp_pd <= rsp_pd;
    end
  end

  // a response traces back to a read or non-posted write strobed two edges ago
  a_rsp_follows_req: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    mcif2csb_resp_valid |-> $past(csb2mcif_req_pvld &&
                                  (!csb2mcif_req_pd.write || csb2mcif_req_pd.nposted), 2)
  ) else $error("response without a matching request");

  a_rsp_known: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    mcif2csb_resp_valid |-> !$isunknown(mcif2csb_resp_pd)
  ) else $error("response payload unknown while valid");

endmodule

// ==== hw/mcif_cfg_top.sv ====
// ==========================================================
// MCIF config slave top level; connects the CSB port, the
// idle status and the datapath configuration
// ==========================================================
`timescale 1ns/1ps
module mcif_cfg_top (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  logic                    csb2mcif_req_pvld,
  input  csb_pkg::csb_req_t       csb2mcif_req_pd,
  input  logic                    dp2reg_idle,
  output logic                    mcif2csb_resp_valid,
  output csb_pkg::csb_rsp_t       mcif2csb_resp_pd,
  output mcif_reg_pkg::mcif_cfg_t reg2dp_cfg
);

  // protocol block, owns the register file
  mcif_csb u_csb (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .csb2mcif_req_pvld   (csb2mcif_req_pvld),
    .csb2mcif_req_pd     (csb2mcif_req_pd),
    .dp2reg_idle         (dp2reg_idle),
    .mcif2csb_resp_valid (mcif2csb_resp_valid),
    .mcif2csb_resp_pd    (mcif2csb_resp_pd),
    .reg2dp_cfg          (reg2dp_cfg)
  );

endmodule

// ==== tests/tb_mcif_cfg.sv ====
// ==========================================================
// testbench for the MCIF config slave; replays the stimulus
// file and checks responses and the configuration output
// ==========================================================
`timescale 1ns/1ps
module tb_mcif_cfg;

  typedef struct packed {
    logic [3:0]  op;    // [1:0] access type, [2] back to back
    logic [21:0] addr;
    logic [31:0] wdat;
    logic [3:0]  be;
    logic [31:0] rdat;
    logic        err;
  } stim_line_t;

  typedef struct packed {
    logic        kind;
    logic        err;
    logic [31:0] rdat;
    int unsigned due;  // cycle the response is owed in
  } exp_rsp_t;

  logic                    nvdla_core_clk;
  logic                    nvdla_core_rstn;
  logic                    csb2mcif_req_pvld;
  csb_pkg::csb_req_t       csb2mcif_req_pd;
  logic                    dp2reg_idle;
  logic                    mcif2csb_resp_valid;
  csb_pkg::csb_rsp_t       mcif2csb_resp_pd;
  mcif_reg_pkg::mcif_cfg_t reg2dp_cfg;

  stim_line_t              lines[$];
  exp_rsp_t                exp_q[$];
  logic [31:0]             shadow[6];  // register map model
  mcif_reg_pkg::mcif_cfg_t cfg_d1;
  mcif_reg_pkg::mcif_cfg_t cfg_d2;
  int unsigned             cycle = 0;
  int                      errors = 0;
  int                      rsp_errors = 0;
  int                      n_rsp = 0;
  int                      n_rsp_exp = 0;
  logic                    idle_next;
  logic                    idle_now;
  logic                    loaded = 1'b0;

  mcif_cfg_top dut_i (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .csb2mcif_req_pvld   (csb2mcif_req_pvld),
    .csb2mcif_req_pd     (csb2mcif_req_pd),
    .dp2reg_idle         (dp2reg_idle),
    .mcif2csb_resp_valid (mcif2csb_resp_valid),
    .mcif2csb_resp_pd    (mcif2csb_resp_pd),
    .reg2dp_cfg          (reg2dp_cfg)
  );

  initial nvdla_core_clk = 1'b0;
  always #4 nvdla_core_clk = ~nvdla_core_clk;

  function automatic logic [31:0] byte_rev(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // struct fields run from the low byte of each word up
  function automatic mcif_reg_pkg::mcif_cfg_t model_cfg();
    return {shadow[0][7:0], shadow[0][15:8], byte_rev(shadow[1]), byte_rev(shadow[2]),
            byte_rev(shadow[3]), byte_rev(shadow[4]), byte_rev(shadow[5])};
  endfunction

  always @(posedge nvdla_core_clk) begin
    cycle  <= cycle + 1;
    cfg_d1 <= model_cfg();  // cfg lags the strobe by two edges
    cfg_d2 <= cfg_d1;
  end

  // idle level lands in the cycle the register file is read
  initial begin
    dp2reg_idle = 1'b0;
    forever begin
      @(posedge nvdla_core_clk);
      idle_now = idle_next;
      #1;
      dp2reg_idle = idle_now;
    end
  end

  task automatic drive_request(input stim_line_t s);
    csb_pkg::csb_req_t req;
    exp_rsp_t          e;
    logic [9:0]        offset;
    req         = '0;
    req.addr    = s.addr;
    req.wdat    = s.wdat;
    req.wrbe    = s.be;
    req.write   = (s.op[1:0] != 2'd0);
    req.nposted = (s.op[1:0] == 2'd2);
    csb2mcif_req_pd   = req;
    csb2mcif_req_pvld = 1'b1;
    offset = s.addr[9:0];
    if (!req.write) begin
      idle_next = s.wdat[0];
      if (offset < 10'd6 && s.rdat !== shadow[offset[2:0]]) begin
        $display("ERROR: stimulus line for offset %0d disagrees with the register model", offset);
        errors++;
      end
    end else if (offset < 10'd6) begin
      for (int b = 0; b < 4; b++) begin
        if (s.be[b] && (offset != 10'd0 || b < 2)) begin  // os_cnt has two bytes only
          shadow[offset[2:0]][8*b +: 8] = s.wdat[8*b +: 8];
        end
      end
    end
    if (!req.write || req.nposted) begin
      e.kind = req.write;
      e.err  = s.err;
      e.rdat = req.write ? 32'h0 : s.rdat;
      e.due  = cycle + 2;
      exp_q.push_back(e);
      n_rsp_exp++;
    end
  endtask

  // ========================================================
  // response and configuration monitor
  // ========================================================
  always @(negedge nvdla_core_clk) begin
    exp_rsp_t e;
    if (nvdla_core_rstn) begin
      if (reg2dp_cfg !== cfg_d2) begin
        $display("FAILED reg2dp_cfg: got %h expected %h", reg2dp_cfg, cfg_d2);
        rsp_errors++;
      end
      if (mcif2csb_resp_valid) begin
        n_rsp++;
        if (exp_q.size() == 0) begin
          $display("ERROR: response valid while no request was outstanding");
          rsp_errors++;
        end else begin
          e = exp_q.pop_front();
          if (cycle != e.due) begin
            $display("ERROR: response came in cycle %0d instead of cycle %0d", cycle, e.due);
            rsp_errors++;
          end
          if (mcif2csb_resp_pd.kind !== e.kind) begin
            $display("FAILED mcif2csb_resp_pd.kind: got %h expected %h",
                     mcif2csb_resp_pd.kind, e.kind);
            rsp_errors++;
          end
          if (mcif2csb_resp_pd.error !== e.err) begin
            $display("FAILED mcif2csb_resp_pd.error: got %h expected %h",
                     mcif2csb_resp_pd.error, e.err);
            rsp_errors++;
          end
          if (mcif2csb_resp_pd.rdat !== e.rdat) begin
            $display("FAILED mcif2csb_resp_pd.rdat: got %h expected %h",
                     mcif2csb_resp_pd.rdat, e.rdat);
            rsp_errors++;
          end
        end
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (lines.size() * 4 + 50) @(posedge nvdla_core_clk);
    $display("ERROR: timeout, the responses did not drain in time");
    $display("RESULT: FAIL");
    $finish;
  end

  // ========================================================
  // main sequence
  // ========================================================
  initial begin
    int          fd;
    int          gap;
    string       text;
    stim_line_t  s;
    logic [31:0] c_op, c_addr, c_wdat, c_be, c_rdat, c_err;
    void'($urandom(92));
    nvdla_core_rstn   = 1'b0;
    csb2mcif_req_pvld = 1'b0;
    csb2mcif_req_pd   = '0;
    idle_next         = 1'b0;
    shadow[0]         = 32'h0000_ffff;
    for (int r = 1; r < 6; r++) begin
      shadow[r] = 32'h0101_0101;
    end
    fd = $fopen("tests/mcif_csb_stimulus.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the stimulus file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        text = "";
        void'($fgets(text, fd));
        if ($sscanf(text, "%h %h %h %h %h %h",
                    c_op, c_addr, c_wdat, c_be, c_rdat, c_err) == 6) begin  // skips comments
          s.op   = c_op[3:0];
          s.addr = c_addr[21:0];
          s.wdat = c_wdat;
          s.be   = c_be[3:0];
          s.rdat = c_rdat;
          s.err  = c_err[0];
          lines.push_back(s);
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;

    repeat (4) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    @(posedge nvdla_core_clk);
    #1;
    foreach (lines[i]) begin
      s   = lines[i];
      gap = s.op[2] ? 0 : int'($urandom % 3);
      repeat (gap) begin
        csb2mcif_req_pvld = 1'b0;
        @(posedge nvdla_core_clk);
        #1;
      end
      drive_request(s);
      @(posedge nvdla_core_clk);
      #1;
    end
    csb2mcif_req_pvld = 1'b0;
    while (exp_q.size() != 0) @(posedge nvdla_core_clk);
    repeat (4) @(posedge nvdla_core_clk);  // catch stray responses

    if (n_rsp != n_rsp_exp) begin
      $display("ERROR: %0d responses seen but %0d were expected", n_rsp, n_rsp_exp);
      errors++;
    end
    $display("responses %0d, stimulus errors %0d, response errors %0d",
             n_rsp, errors, rsp_errors);
    if (errors == 0 && rsp_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/csb_pkg.sv
hw/mcif_reg_pkg.sv
hw/mcif_csb_reg.sv
hw/mcif_csb.sv
hw/mcif_cfg_top.sv
tests/tb_mcif_cfg.sv

// ==== run.sh ====
#!/bin/sh
# builds the MCIF config slave testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mcif_cfg -f sources.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

// ==== tests/mcif_csb_stimulus.txt ====
# op addr wdata wrbe exp_rdat exp_err, all hex; op 0 read, 1 posted, 2 non-posted write
# op + 4 issues the line back to back; for reads bit 0 of wdata is the idle level
0 000000 00000000 0 0000ffff 0
0 000001 00000000 0 01010101 0
0 000002 00000000 0 01010101 0
0 000003 00000000 0 01010101 0
0 000004 00000000 0 01010101 0
0 000005 00000000 0 01010101 0
0 000006 00000001 0 00000001 0
2 000001 44332211 f 00000000 0
0 000001 00000000 0 44332211 0
2 000000 12345678 f 00000000 0
0 000000 00000000 0 00005678 0
2 000004 aabbccdd 5 00000000 0
0 000004 00000000 0 01bb01dd 0
2 000002 99887766 a 00000000 0
0 000002 00000000 0 99017701 0
1 000003 deadbeef f 00000000 0
0 000003 00000000 0 deadbeef 0
1 000005 0000c300 2 00000000 0
0 000005 00000000 0 0101c301 0
0 000006 00000000 0 00000000 0
2 000006 ffffffff f 00000000 1
1 000006 ffffffff f 00000000 1
0 000007 00000000 0 00000000 1
2 00000f 12345678 f 00000000 1
0 000010 00000000 0 00000000 1
2 0003ff 11111111 f 00000000 1
2 000001 cafef00d f 00000000 0
4 000001 00000000 0 cafef00d 0
6 000004 00000055 1 00000000 0
4 000004 00000000 0 01bb0155 0
5 000000 0000aa00 2 00000000 0
4 000000 00000000 0 0000aa78 0
4 000006 00000001 0 00000001 0
4 000006 00000000 0 00000000 0
